// ==== rtl/pixel_pkg.sv ====
/*
 pixel payload types for the luma path, 8-bit RGB input only
 luma weights sum to 256 so the weighted sum fits 16 bits unsigned
*/

package pixel_pkg;

	// --------------------
	// payload types
	// --------------------

	// one input pixel, r in the top byte
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef logic [7:0] luma_t;

	// --------------------
	// luma weights
	// --------------------

	// BT.601 approximation, luma = (77r + 150g + 29b) >> 8
	localparam logic [7:0] COEF_R = 8'd77;
	localparam logic [7:0] COEF_G = 8'd150;
	localparam logic [7:0] COEF_B = 8'd29;

endpackage

// ==== rtl/stream_pkg.sv ====
/*
 AXI4-Stream sideband layout and frame geometry defaults
 only tuser bit 0 (frame start) carries meaning, higher bits are sent as 0
*/

package stream_pkg;

	// --------------------
	// tuser layout
	// --------------------

	localparam int TUSER_WIDTH = 1;

	// frame start marker position
	localparam int TUSER_FS_BIT = 0;

	// --------------------
	// frame geometry
	// --------------------

	// lines per frame unless the top is told otherwise
	localparam int DEF_IMG_HEIGHT = 480;

endpackage

// ==== rtl/img_if.sv ====
/*
 image bus between pixel stages, flags only meaningful while valid is high
 de always equals valid in this design, no blanking is carried
*/

`timescale 1ns/1ns

interface img_if #(
	parameter type data_t = logic [7:0]
);

	logic  line_first;
	logic  line_last;
	logic  pixel_first;
	logic  pixel_last;
	logic  de;
	data_t data;
	logic  valid;

	// producer side
	modport src (
		output line_first,
		output line_last,
		output pixel_first,
		output pixel_last,
		output de,
		output data,
		output valid
	);

	// consumer side
	modport snk (
		input line_first,
		input line_last,
		input pixel_first,
		input pixel_last,
		input de,
		input data,
		input valid
	);

endinterface

// ==== rtl/axi4s_to_img.sv ====
/*
 AXI4-Stream to image bus, one cycle latency, tready is cke at the top
 frames must be exactly IMG_HEIGHT lines, malformed frames are not repaired
*/

`timescale 1ns/1ns

module axi4s_to_img #(
	parameter int IMG_HEIGHT = stream_pkg::DEF_IMG_HEIGHT
) (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               cke,
	input  pixel_pkg::rgb_t                    s_tdata,
	input  logic [stream_pkg::TUSER_WIDTH-1:0] s_tuser,
	input  logic                               s_tlast,
	input  logic                               s_tvalid,
	img_if.src                                 m_img
);

	localparam int ROW_W = (IMG_HEIGHT > 1) ? $clog2(IMG_HEIGHT) : 1;
	localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(IMG_HEIGHT - 1);

	logic             frame_start;
	logic             pixel_first_pend;
	logic [ROW_W-1:0] row_cnt;
	logic [ROW_W-1:0] row_cur;
	logic             last_row;

	assign frame_start = s_tuser[stream_pkg::TUSER_FS_BIT];

	// frame start forces row 0 for the current beat
	assign row_cur  = frame_start ? '0 : row_cnt;
	assign last_row = (row_cur == LAST_ROW);

	// --------------------
	// row and pixel tracking
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			row_cnt          <= '0;
			pixel_first_pend <= 1'b1;
			m_img.valid      <= 1'b0;
			m_img.de         <= 1'b0;
		end else if (cke) begin
			m_img.valid <= s_tvalid;
			m_img.de    <= s_tvalid;
			if (s_tvalid) begin
				// next beat opens a line after tlast
				pixel_first_pend <= s_tlast;
				if (s_tlast) begin
					row_cnt <= last_row ? '0 : row_cur + 1'b1;
				end else begin
					row_cnt <= row_cur;
				end
			end
		end
	end

	// --------------------
	// payload and flags
	// --------------------

	always_ff @(posedge clk) begin
		if (cke) begin
			m_img.data        <= s_tdata;
			m_img.line_first  <= (row_cur == '0);
			m_img.line_last   <= last_row;
			m_img.pixel_first <= frame_start | pixel_first_pend;
			m_img.pixel_last  <= s_tlast;
		end
	end

endmodule

// ==== rtl/img_luma.sv ====
/*
 RGB to 8-bit luma in two cke stages, optional threshold to 0 or 255
 threshold and binarize are sampled with the pixel in stage one
*/

`timescale 1ns/1ns

module img_luma (
	input  logic               clk,
	input  logic               reset,
	input  logic               cke,
	input  pixel_pkg::luma_t   threshold,
	input  logic               binarize,
	img_if.snk                 s_img,
	img_if.src                 m_img
);

	logic [15:0]      prod_r;
	logic [15:0]      prod_g;
	logic [15:0]      prod_b;
	logic [15:0]      sum;
	pixel_pkg::luma_t luma;
	pixel_pkg::luma_t thr_q;
	logic             bin_q;

	// {line_first, line_last, pixel_first, pixel_last, de, valid}
	logic [5:0] flags_in;
	logic [5:0] flags_sr [2];

	assign flags_in = {s_img.line_first, s_img.line_last, s_img.pixel_first,
		s_img.pixel_last, s_img.de, s_img.valid};

	// --------------------
	// sideband delay
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			flags_sr[0] <= '0;
			flags_sr[1] <= '0;
		end else if (cke) begin
			flags_sr[0] <= flags_in;
			flags_sr[1] <= flags_sr[0];
		end
	end

	assign {m_img.line_first, m_img.line_last, m_img.pixel_first,
		m_img.pixel_last, m_img.de, m_img.valid} = flags_sr[1];

	// --------------------
	// stage one, products
	// --------------------

	always_ff @(posedge clk) begin
		if (cke) begin
			prod_r <= 16'(s_img.data.r) * 16'(pixel_pkg::COEF_R);
			prod_g <= 16'(s_img.data.g) * 16'(pixel_pkg::COEF_G);
			prod_b <= 16'(s_img.data.b) * 16'(pixel_pkg::COEF_B);
			thr_q  <= threshold;
			bin_q  <= binarize;
		end
	end

	// --------------------
	// stage two, sum and threshold
	// --------------------

	// weights sum to 256, so no overflow at full white
	assign sum  = prod_r + prod_g + prod_b;
	assign luma = sum[15:8];

	always_ff @(posedge clk) begin
		if (cke) begin
			if (bin_q) begin
				m_img.data <= (luma >= thr_q) ? 8'hff : 8'h00;
			end else begin
				m_img.data <= luma;
			end
		end
	end

endmodule

// ==== rtl/img_to_axi4s.sv ====
/*
 image bus to AXI4-Stream, one cycle latency, all registers advance on cke
 tvalid is held through a stall, so cke must equal the downstream tready
*/

`timescale 1ns/1ns

module img_to_axi4s (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               cke,
	img_if.snk                                 s_img,
	output pixel_pkg::luma_t                   m_tdata,
	output logic [stream_pkg::TUSER_WIDTH-1:0] m_tuser,
	output logic                               m_tlast,
	output logic                               m_tvalid
);

	logic [stream_pkg::TUSER_WIDTH-1:0] tuser_next;

	// frame start on the first pixel of the first line, upper bits stay 0
	always_comb begin
		tuser_next = '0;
		tuser_next[stream_pkg::TUSER_FS_BIT] = s_img.valid & s_img.line_first &
			s_img.pixel_first;
	end

	// --------------------
	// handshake
	// --------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			m_tvalid <= 1'b0;
		end else if (cke) begin
			m_tvalid <= s_img.de;
		end
	end

	// --------------------
	// beat contents
	// --------------------

	always_ff @(posedge clk) begin
		if (cke) begin
			m_tdata <= s_img.data;
			m_tuser <= tuser_next;
			m_tlast <= s_img.valid & s_img.pixel_last;
		end
	end

endmodule

// ==== rtl/img_luma_axi4s.sv ====
/*
 RGB AXI4-Stream in, luma AXI4-Stream out, 4 cycles of latency
 s_axis_tready follows m_axis_tready directly, the whole path stalls together
*/

`timescale 1ns/1ns

module img_luma_axi4s #(
	parameter int IMG_HEIGHT = stream_pkg::DEF_IMG_HEIGHT
) (
	input  logic                               clk,
	input  logic                               reset,

	input  pixel_pkg::rgb_t                    s_axis_tdata,
	input  logic [stream_pkg::TUSER_WIDTH-1:0] s_axis_tuser,
	input  logic                               s_axis_tlast,
	input  logic                               s_axis_tvalid,
	output logic                               s_axis_tready,

	output pixel_pkg::luma_t                   m_axis_tdata,
	output logic [stream_pkg::TUSER_WIDTH-1:0] m_axis_tuser,
	output logic                               m_axis_tlast,
	output logic                               m_axis_tvalid,
	input  logic                               m_axis_tready,

	input  pixel_pkg::luma_t                   threshold,
	input  logic                               binarize
);

	logic cke;

	// one enable for every stage
	assign cke           = m_axis_tready;
	assign s_axis_tready = cke;

	img_if #(.data_t(pixel_pkg::rgb_t))  rgb ();
	img_if #(.data_t(pixel_pkg::luma_t)) luma ();

	// --------------------
	// stages
	// --------------------

	axi4s_to_img #(
		.IMG_HEIGHT (IMG_HEIGHT)
	) u_axi4s_to_img (
		.clk      (clk),
		.reset    (reset),
		.cke      (cke),
		.s_tdata  (s_axis_tdata),
		.s_tuser  (s_axis_tuser),
		.s_tlast  (s_axis_tlast),
		.s_tvalid (s_axis_tvalid),
		.m_img    (rgb.src)
	);

	img_luma u_img_luma (
		.clk       (clk),
		.reset     (reset),
		.cke       (cke),
		.threshold (threshold),
		.binarize  (binarize),
		.s_img     (rgb.snk),
		.m_img     (luma.src)
	);

	img_to_axi4s u_img_to_axi4s (
		.clk      (clk),
		.reset    (reset),
		.cke      (cke),
		.s_img    (luma.snk),
		.m_tdata  (m_axis_tdata),
		.m_tuser  (m_axis_tuser),
		.m_tlast  (m_axis_tlast),
		.m_tvalid (m_axis_tvalid)
	);

endmodule

// ==== testbench/img_luma_chk.sv ====
/*
 protocol assertions on the top-level output stream, bound into img_luma_axi4s
*/

`timescale 1ns/1ns

module img_luma_chk (
	input logic                               clk,
	input logic                               reset,
	input pixel_pkg::luma_t                   m_axis_tdata,
	input logic [stream_pkg::TUSER_WIDTH-1:0] m_axis_tuser,
	input logic                               m_axis_tlast,
	input logic                               m_axis_tvalid,
	input logic                               m_axis_tready
);

	// high between the first beat of a line and its tlast
	logic line_open;

	// number of failed assertions so far
	int fail_count = 0;

	always_ff @(posedge clk) begin
		if (reset) begin
			line_open <= 1'b0;
		end else if (m_axis_tvalid && m_axis_tready) begin
			line_open <= !m_axis_tlast;
		end
	end

	reset_clears_valid: assert property (@(posedge clk) reset |=> !m_axis_tvalid)
		else begin
			fail_count++;
			$error("m_axis_tvalid high in the cycle after reset");
		end

	stall_holds_beat: assert property (@(posedge clk) disable iff (reset)
		(m_axis_tvalid && !m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis_tdata) &&
		$stable(m_axis_tuser) && $stable(m_axis_tlast)))
		else begin
			fail_count++;
			$error("output beat changed while stalled");
		end

	// a frame start inside a line would close a line that did not start the frame
	frame_start_opens_line: assert property (@(posedge clk) disable iff (reset)
		(m_axis_tvalid && m_axis_tuser[0]) |-> !line_open)
		else begin
			fail_count++;
			$error("tuser frame start in the middle of a line");
		end

endmodule

bind img_luma_axi4s img_luma_chk chk (
	.clk           (clk),
	.reset         (reset),
	.m_axis_tdata  (m_axis_tdata),
	.m_axis_tuser  (m_axis_tuser),
	.m_axis_tlast  (m_axis_tlast),
	.m_axis_tvalid (m_axis_tvalid),
	.m_axis_tready (m_axis_tready)
);

// ==== testbench/tb_img_luma_axi4s.sv ====
/*
 testbench for the luma path, three 4x3 frames from a table under random tready
 threshold and binarize change only after the previous frame has left the DUT
*/

`timescale 1ns/1ns

module tb_img_luma_axi4s;

	localparam int IMG_W       = 4;
	localparam int IMG_H       = 3;
	localparam int FRAME       = IMG_W * IMG_H;
	localparam int N_PIX       = 3 * FRAME;
	localparam int IDLE_CYCLES = 6;
	localparam int T_CLK       = 8;
	localparam int WATCHDOG_NS = (N_PIX * 8 + 100) * T_CLK;

	typedef struct {
		pixel_pkg::rgb_t  rgb;
		logic             bin;
		pixel_pkg::luma_t thr;
		pixel_pkg::luma_t exp_data;
		logic             exp_user;
		logic             exp_last;
	} entry_t;

	logic                               clk;
	logic                               reset;
	pixel_pkg::rgb_t                    s_axis_tdata;
	logic [stream_pkg::TUSER_WIDTH-1:0] s_axis_tuser;
	logic                               s_axis_tlast;
	logic                               s_axis_tvalid;
	logic                               s_axis_tready;
	pixel_pkg::luma_t                   m_axis_tdata;
	logic [stream_pkg::TUSER_WIDTH-1:0] m_axis_tuser;
	logic                               m_axis_tlast;
	logic                               m_axis_tvalid;
	logic                               m_axis_tready;
	pixel_pkg::luma_t                   threshold;
	logic                               binarize;

	entry_t stim [N_PIX];
	int     in_count;
	int     out_count;

	img_luma_axi4s #(
		.IMG_HEIGHT (IMG_H)
	) uut (
		.clk           (clk),
		.reset         (reset),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tuser  (s_axis_tuser),
		.s_axis_tlast  (s_axis_tlast),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tlast  (m_axis_tlast),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.threshold     (threshold),
		.binarize      (binarize)
	);

	initial begin
		clk = 1'b0;
		forever #(T_CLK / 2) clk = ~clk;
	end

	// --------------------
	// reference model and checks
	// --------------------

	// luma = (77r + 150g + 29b) >> 8, then optional threshold
	function automatic pixel_pkg::luma_t expected_luma(pixel_pkg::rgb_t px, logic bin,
		pixel_pkg::luma_t thr);
		int y;
		y = (77 * px.r + 150 * px.g + 29 * px.b) >> 8;
		if (!bin) begin
			return pixel_pkg::luma_t'(y);
		end
		return (y >= thr) ? 8'hff : 8'h00;
	endfunction

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_luma(input string name, input pixel_pkg::luma_t expected,
		input pixel_pkg::luma_t observed);
		if (observed !== expected) begin
			$display("** Error at %0t ns: %s expected %0d, observed %0d", $time, name,
				expected, observed);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic observed);
		if (observed !== expected) begin
			$display("** Error at %0t ns: %s expected %b, observed %b", $time, name,
				expected, observed);
			abort_run();
		end
	endtask

	// frame one plain, frame two threshold 128, frame three threshold 0
	task automatic fill_stimulus();
		int              i;
		int              f;
		pixel_pkg::rgb_t px;
		for (i = 0; i < N_PIX; i++) begin
			f  = i / FRAME;
			px = pixel_pkg::rgb_t'($urandom);
			case (i)
				0:         px = '{8'hff, 8'hff, 8'hff};
				1:         px = '{8'h00, 8'h00, 8'h00};
				2:         px = '{8'hff, 8'h00, 8'h00};
				FRAME:     px = '{8'd128, 8'd128, 8'd128};
				FRAME + 1: px = '{8'd127, 8'd127, 8'd127};
				2 * FRAME: px = '{8'h00, 8'h00, 8'h00};
				default:   ;
			endcase
			stim[i].rgb      = px;
			stim[i].bin      = (f != 0);
			stim[i].thr      = (f == 1) ? 8'd128 : 8'd0;
			stim[i].exp_data = expected_luma(px, stim[i].bin, stim[i].thr);
			stim[i].exp_user = (i % FRAME == 0);
			stim[i].exp_last = (i % IMG_W == IMG_W - 1);
		end
	endtask

	// --------------------
	// output monitor, sampled mid-cycle
	// --------------------

	initial begin : monitor
		forever begin
			@(negedge clk);
			if (uut.chk.fail_count != 0) begin
				$display("a protocol assertion on the output stream failed by %0t ns", $time);
				abort_run();
			end
			if (!reset && m_axis_tvalid && in_count == 0) begin
				$display("output beat at %0t ns before any input was accepted", $time);
				abort_run();
			end
			if (!reset && m_axis_tvalid && m_axis_tready) begin
				if (out_count >= N_PIX) begin
					$display("extra output beat at %0t ns after all pixels were seen", $time);
					abort_run();
				end else begin
					check_luma("m_axis_tdata", stim[out_count].exp_data, m_axis_tdata);
					check_flag("m_axis_tuser[0]", stim[out_count].exp_user, m_axis_tuser[0]);
					check_flag("m_axis_tlast", stim[out_count].exp_last, m_axis_tlast);
					out_count++;
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: only %0d of %0d output beats after %0t ns", out_count, N_PIX,
			$time);
		abort_run();
	end

	// --------------------
	// stimulus
	// --------------------

	initial begin : main
		int   idle;
		logic accepted;
		void'($urandom(32'h6a3e8d77));
		reset         = 1'b1;
		s_axis_tdata  = '0;
		s_axis_tuser  = '0;
		s_axis_tlast  = 1'b0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		threshold     = 8'd0;
		binarize      = 1'b0;
		in_count      = 0;
		out_count     = 0;
		idle          = IDLE_CYCLES;
		fill_stimulus();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		while (out_count < N_PIX) begin
			@(posedge clk);
			accepted = s_axis_tvalid && s_axis_tready;
			if (accepted) begin
				in_count++;
			end
			#1;
			m_axis_tready = ($urandom % 4) != 0;
			// an offered beat stays unchanged until it is taken
			if (!(s_axis_tvalid && !accepted)) begin
				if (idle > 0 || in_count >= N_PIX) begin
					idle          = (idle > 0) ? idle - 1 : 0;
					s_axis_tvalid = 1'b0;
				end else if ((stim[in_count].bin !== binarize ||
					stim[in_count].thr !== threshold) && out_count < in_count) begin
					// new settings wait for the pipeline to drain
					s_axis_tvalid = 1'b0;
				end else begin
					binarize      = stim[in_count].bin;
					threshold     = stim[in_count].thr;
					s_axis_tdata  = stim[in_count].rgb;
					s_axis_tuser  = '0;
					s_axis_tuser[0] = stim[in_count].exp_user;
					s_axis_tlast  = stim[in_count].exp_last;
					s_axis_tvalid = ($urandom % 4) != 0;
				end
			end
		end
		@(posedge clk);
		#1;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b1;
		repeat (8) @(posedge clk);
		if (uut.chk.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("SOME TESTS FAILED");
			$fatal(1, "protocol assertions failed");
		end
	end

endmodule

// ==== img_luma_axi4s.f ====
rtl/pixel_pkg.sv
rtl/stream_pkg.sv
rtl/img_if.sv
rtl/axi4s_to_img.sv
rtl/img_luma.sv
rtl/img_to_axi4s.sv
rtl/img_luma_axi4s.sv
testbench/img_luma_chk.sv
testbench/tb_img_luma_axi4s.sv
